// File: Makefile
.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module tb_ldq

sim:
	verilator --binary --timing --assert -f verilog.f --top-module tb_ldq -o Vtb_ldq
	-./obj_dir/Vtb_ldq > sim.log 2>&1
	cat sim.log
	@if grep -q "Simulation FAILED" sim.log; then exit 1; fi
	@grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: logic/ldq.sv
`default_nettype none

module ldq (
  input  logic                          i_clk,
  input  logic                          i_reset_n,

  input  logic [ldq_pkg::DISP_SIZE-1:0] i_disp_valid,
  input  ldq_pkg::disp_grp_t            i_disp,

  input  ldq_pkg::ex2_update_t          i_ex2_update,
  input  logic                          i_tlb_resolve,
  input  ldq_pkg::lrq_resolve_t         i_lrq_resolve,
  input  ldq_pkg::stq_resolve_t         i_stq_resolve,
  input  ldq_pkg::commit_t              i_commit,

  input  logic                          i_replay_conflict,
  output ldq_pkg::replay_t              o_replay,

  output ldq_pkg::done_rpt_t            o_done_report,
  output ldq_pkg::credit_ret_t          o_credit_return
);

ldq_pkg::ldq_entry_t w_ldq_entries [ldq_pkg::LDQ_SIZE];

logic [ldq_pkg::LDQ_SIZE-1:0]  w_entry_finish;
logic [ldq_pkg::LDQ_SIZE-1:0]  w_rerun_request;
logic [ldq_pkg::LDQ_SIZE-1:0]  w_rerun_oh;
logic [ldq_pkg::LDQ_SIZE-1:0]  w_ldq_done_array;
logic [ldq_pkg::LDQ_SIZE-1:0]  w_ldq_done_oh;
ldq_pkg::ldq_entry_t           w_ldq_done_entry;
ldq_pkg::disp_t                w_replay_inst;

logic [ldq_pkg::LDQ_IDX_W-1:0] w_in_ptr;
logic [ldq_pkg::LDQ_IDX_W-1:0] w_slot_ptr [ldq_pkg::DISP_SIZE];
logic [ldq_pkg::CNT_W-1:0]     w_disp_picked_num;
logic [ldq_pkg::CNT_W-1:0]     w_entry_finish_cnt;

logic                          w_flush_valid;
logic                          w_ignore_disp;
logic [ldq_pkg::CNT_W-1:0]     w_credit_return_val;

assign w_flush_valid = i_commit.commit & i_commit.flush_valid;

// ----------------------------------------
// Dispatch packing
// ----------------------------------------
// Each valid slot lands after the valid slots below it
always_comb begin
  w_disp_picked_num = '0;
  for (int d = 0; d < ldq_pkg::DISP_SIZE; d++) begin
    w_slot_ptr[d] = w_in_ptr + w_disp_picked_num[ldq_pkg::LDQ_IDX_W-1:0];
    if (i_disp_valid[d]) w_disp_picked_num = w_disp_picked_num + ldq_pkg::CNT_ONE;
  end
end

always_comb begin
  w_entry_finish_cnt = '0;
  for (int l = 0; l < ldq_pkg::LDQ_SIZE; l++) begin
    if (w_entry_finish[l]) w_entry_finish_cnt = w_entry_finish_cnt + ldq_pkg::CNT_ONE;
  end
end

ldq_ptr u_ldq_ptr (
  .i_clk       (i_clk),
  .i_reset_n   (i_reset_n),
  .i_rollback  (w_flush_valid),
  .i_in_valid  (|i_disp_valid),
  .i_in_val    (w_disp_picked_num[ldq_pkg::LDQ_IDX_W-1:0]),
  .i_out_valid (|w_entry_finish),
  .i_out_val   (w_entry_finish_cnt[ldq_pkg::LDQ_IDX_W-1:0]),
  .o_in_ptr    (w_in_ptr),
  .o_out_ptr   ()
);

// ----------------------------------------
// Credit return
// ----------------------------------------
assign w_ignore_disp = w_flush_valid & (|i_disp_valid);
assign w_credit_return_val = w_entry_finish_cnt + (w_ignore_disp ? w_disp_picked_num : '0);

ldq_credit_return u_credit_return (
  .i_clk           (i_clk),
  .i_reset_n       (i_reset_n),
  .i_alloc_num     (w_disp_picked_num),  // Discarded loads come back in the same pulse
  .i_get_return    ((|w_entry_finish) | w_ignore_disp),
  .i_return_val    (w_credit_return_val),
  .o_credit_return (o_credit_return)
);

// ----------------------------------------
// Entry array
// ----------------------------------------
generate for (genvar l_idx = 0; l_idx < ldq_pkg::LDQ_SIZE; l_idx++) begin : ldq_loop
  logic [ldq_pkg::DISP_SIZE-1:0] w_input_valid;
  ldq_pkg::disp_t                w_disp_entry;
  ldq_pkg::ex2_update_t          w_ex2_update;

  always_comb begin
    w_input_valid = '0;
    w_disp_entry  = '0;
    for (int d = 0; d < ldq_pkg::DISP_SIZE; d++) begin
      if (i_disp_valid[d] && !w_flush_valid &&
          (w_slot_ptr[d] == l_idx[ldq_pkg::LDQ_IDX_W-1:0])) begin
        w_input_valid[d] = 1'b1;
        w_disp_entry     = i_disp.inst[d];
      end
    end
  end

  // Only this entry's bit of index_oh is passed on
  always_comb begin
    w_ex2_update                 = i_ex2_update;
    w_ex2_update.index_oh        = '0;
    w_ex2_update.index_oh[l_idx] = i_ex2_update.index_oh[l_idx];
  end

  ldq_entry u_ldq_entry (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_disp_load    (|w_input_valid),
    .i_disp_cmt_id  (i_disp.cmt_id),
    .i_disp_grp_id  (w_input_valid),
    .i_disp         (w_disp_entry),
    .i_rerun_accept (w_rerun_oh[l_idx] & !i_replay_conflict),
    .i_ex2_update   (w_ex2_update),
    .i_tlb_resolve  (i_tlb_resolve),
    .i_lrq_resolve  (i_lrq_resolve),
    .i_stq_resolve  (i_stq_resolve),
    .i_commit       (i_commit),
    .i_done_accept  (w_ldq_done_oh[l_idx]),
    .o_entry        (w_ldq_entries[l_idx]),
    .o_entry_finish (w_entry_finish[l_idx])
  );

  assign w_rerun_request[l_idx]  = w_ldq_entries[l_idx].state == ldq_pkg::LDQ_READY;
  assign w_ldq_done_array[l_idx] = w_ldq_entries[l_idx].state == ldq_pkg::LDQ_EX3_DONE;
end
endgenerate

// Replay picks the lowest index
always_comb begin
  w_rerun_oh    = '0;
  w_replay_inst = '0;
  for (int l = ldq_pkg::LDQ_SIZE - 1; l >= 0; l--) begin
    if (w_rerun_request[l]) begin
      w_rerun_oh    = '0;
      w_rerun_oh[l] = 1'b1;
      w_replay_inst = w_ldq_entries[l].inst;
    end
  end
end

assign o_replay.valid    = |w_rerun_request;
assign o_replay.inst     = w_replay_inst;
assign o_replay.index_oh = w_rerun_oh;

// Done picks the highest index
always_comb begin
  w_ldq_done_oh    = '0;
  w_ldq_done_entry = '0;
  for (int l = 0; l < ldq_pkg::LDQ_SIZE; l++) begin
    if (w_ldq_done_array[l]) begin
      w_ldq_done_oh    = '0;
      w_ldq_done_oh[l] = 1'b1;
      w_ldq_done_entry = w_ldq_entries[l];
    end
  end
end

assign o_done_report.valid  = |w_ldq_done_oh;
assign o_done_report.cmt_id = w_ldq_done_entry.cmt_id;
assign o_done_report.grp_id = w_ldq_done_entry.grp_id;

endmodule

`default_nettype wire

// File: logic/ldq_credit_return.sv
`default_nettype none

module ldq_credit_return (
  input  logic                      i_clk,
  input  logic                      i_reset_n,

  input  logic [ldq_pkg::CNT_W-1:0] i_alloc_num,

  input  logic                      i_get_return,
  input  logic [ldq_pkg::CNT_W-1:0] i_return_val,

  output ldq_pkg::credit_ret_t      o_credit_return
);

logic [ldq_pkg::CNT_W-1:0] r_credits;  // Entries held by the queue
logic [ldq_pkg::CNT_W-1:0] w_credits_next;
logic [ldq_pkg::CNT_W-1:0] w_return_num;

logic                      r_ret_valid;
logic [ldq_pkg::CNT_W-1:0] r_ret_val;

assign w_return_num   = i_get_return ? i_return_val : '0;
assign w_credits_next = r_credits + i_alloc_num - w_return_num;

always_ff @(posedge i_clk) begin
  if (i_reset_n) begin
    r_credits   <= '0;
    r_ret_valid <= 1'b0;
  end else begin
    r_credits   <= w_credits_next;
    r_ret_valid <= i_get_return;
  end
end

always_ff @(posedge i_clk) begin
  r_ret_val <= i_return_val;
end

// One-cycle pulse back to the dispatcher
assign o_credit_return.valid = r_ret_valid;
assign o_credit_return.val   = r_ret_val;

endmodule

`default_nettype wire

// File: logic/ldq_entry.sv
`default_nettype none

module ldq_entry (
  input  logic                          i_clk,
  input  logic                          i_reset_n,

  input  logic                          i_disp_load,
  input  logic [ldq_pkg::CMT_ID_W-1:0]  i_disp_cmt_id,
  input  logic [ldq_pkg::DISP_SIZE-1:0] i_disp_grp_id,
  input  ldq_pkg::disp_t                i_disp,

  input  logic                          i_rerun_accept,
  input  ldq_pkg::ex2_update_t          i_ex2_update,
  input  logic                          i_tlb_resolve,
  input  ldq_pkg::lrq_resolve_t         i_lrq_resolve,
  input  ldq_pkg::stq_resolve_t         i_stq_resolve,
  input  ldq_pkg::commit_t              i_commit,
  input  logic                          i_done_accept,

  output ldq_pkg::ldq_entry_t           o_entry,
  output logic                          o_entry_finish
);

ldq_pkg::ldq_state_e r_state;
ldq_pkg::ldq_state_e w_state_next;

logic [ldq_pkg::CMT_ID_W-1:0]  r_cmt_id;
logic [ldq_pkg::DISP_SIZE-1:0] r_grp_id;
ldq_pkg::disp_t                r_inst;
logic [ldq_pkg::LRQ_IDX_W-1:0] r_lrq_index;
logic [ldq_pkg::STQ_SIZE-1:0]  r_stq_mask;

logic w_valid;
logic w_ex2_hit;
logic w_lrq_hit;
logic w_stq_hit;
logic w_flush;
logic w_commit_hit;
logic w_free;

assign w_valid = r_state != ldq_pkg::LDQ_IDLE;

// index_oh arrives already masked down to this entry's bit
assign w_ex2_hit = i_ex2_update.update & (|i_ex2_update.index_oh);

assign w_lrq_hit = i_lrq_resolve.valid & (i_lrq_resolve.index == r_lrq_index);
assign w_stq_hit = i_stq_resolve.valid & (|(i_stq_resolve.index_oh & r_stq_mask));

// ----------------------------------------
// Commit and flush decode
// ----------------------------------------
assign w_flush = i_commit.commit & i_commit.flush_valid;
assign w_commit_hit = i_commit.commit &
                      (i_commit.cmt_id == r_cmt_id) &
                      (|(i_commit.grp_id & r_grp_id)) &
                      ((r_state == ldq_pkg::LDQ_EX3_DONE) |
                       (r_state == ldq_pkg::LDQ_WAIT_COMPLETE));

assign w_free = (w_valid & w_flush) | w_commit_hit;
assign o_entry_finish = w_free;

// ----------------------------------------
// Entry FSM
// ----------------------------------------
always_comb begin
  w_state_next = r_state;
  case (r_state)
    ldq_pkg::LDQ_IDLE: begin
      if (i_disp_load) w_state_next = ldq_pkg::LDQ_READY;
    end
    ldq_pkg::LDQ_READY: begin
      if (i_rerun_accept) w_state_next = ldq_pkg::LDQ_EX2_RUN;
    end
    ldq_pkg::LDQ_EX2_RUN: begin
      if (w_ex2_hit) begin
        case (i_ex2_update.result)
          ldq_pkg::EX2_OK:       w_state_next = ldq_pkg::LDQ_EX3_DONE;
          ldq_pkg::EX2_LRQ_MISS: w_state_next = ldq_pkg::LDQ_LRQ_HAZ;
          ldq_pkg::EX2_STQ_HAZ:  w_state_next = ldq_pkg::LDQ_STQ_HAZ;
          default:               w_state_next = ldq_pkg::LDQ_TLB_HAZ;
        endcase
      end
    end
    ldq_pkg::LDQ_LRQ_HAZ: begin
      if (w_lrq_hit) w_state_next = ldq_pkg::LDQ_READY;
    end
    ldq_pkg::LDQ_STQ_HAZ: begin
      if (w_stq_hit) w_state_next = ldq_pkg::LDQ_READY;
    end
    ldq_pkg::LDQ_TLB_HAZ: begin
      if (i_tlb_resolve) w_state_next = ldq_pkg::LDQ_READY;  // Releases every TLB hazard
    end
    ldq_pkg::LDQ_EX3_DONE: begin
      if (i_done_accept) w_state_next = ldq_pkg::LDQ_WAIT_COMPLETE;
    end
    ldq_pkg::LDQ_WAIT_COMPLETE: begin
      w_state_next = r_state;  // Held until commit
    end
    default: w_state_next = ldq_pkg::LDQ_IDLE;
  endcase

  if (w_free) w_state_next = ldq_pkg::LDQ_IDLE;
end

always_ff @(posedge i_clk) begin
  if (i_reset_n) begin
    r_state <= ldq_pkg::LDQ_IDLE;
  end else begin
    r_state <= w_state_next;
  end
end

// Payload
always_ff @(posedge i_clk) begin
  if (i_disp_load) begin
    r_cmt_id <= i_disp_cmt_id;
    r_grp_id <= i_disp_grp_id;
    r_inst   <= i_disp;
  end
  if ((r_state == ldq_pkg::LDQ_EX2_RUN) & w_ex2_hit) begin
    r_lrq_index <= i_ex2_update.lrq_index;
    r_stq_mask  <= i_ex2_update.stq_mask;
  end
end

always_comb begin
  o_entry.is_valid  = w_valid;
  o_entry.state     = r_state;
  o_entry.cmt_id    = r_cmt_id;
  o_entry.grp_id    = r_grp_id;
  o_entry.inst      = r_inst;
  o_entry.lrq_index = r_lrq_index;
  o_entry.stq_mask  = r_stq_mask;
end

endmodule

`default_nettype wire

// File: logic/ldq_pkg.sv
`default_nettype none

package ldq_pkg;

// ----------------------------------------
// Sizes
// ----------------------------------------
localparam int LDQ_SIZE  = 8;
localparam int DISP_SIZE = 2;
localparam int CMT_ID_W  = 6;
localparam int LRQ_SIZE  = 4;
localparam int STQ_SIZE  = 8;

localparam int LDQ_IDX_W = $clog2(LDQ_SIZE);
localparam int CNT_W     = LDQ_IDX_W + 1;  // Counts 0 .. LDQ_SIZE
localparam int LRQ_IDX_W = $clog2(LRQ_SIZE);

localparam logic [CNT_W-1:0] CNT_ONE = 1;

// ----------------------------------------
// Encodings
// ----------------------------------------
typedef enum logic [3:0] {
  LDQ_IDLE,
  LDQ_READY,
  LDQ_EX2_RUN,
  LDQ_LRQ_HAZ,
  LDQ_STQ_HAZ,
  LDQ_TLB_HAZ,
  LDQ_EX3_DONE,
  LDQ_WAIT_COMPLETE
} ldq_state_e;

typedef enum logic [1:0] {
  EX2_OK,
  EX2_LRQ_MISS,
  EX2_STQ_HAZ,
  EX2_TLB_MISS
} ex2_result_e;

// ----------------------------------------
// Structs
// ----------------------------------------
typedef struct packed {
  logic [31:0] pc_addr;
  logic [31:0] inst;
} disp_t;

typedef struct packed {
  disp_t [DISP_SIZE-1:0] inst;
  logic [CMT_ID_W-1:0]   cmt_id;  // Shared by the whole group
} disp_grp_t;

typedef struct packed {
  logic                 is_valid;
  ldq_state_e           state;
  logic [CMT_ID_W-1:0]  cmt_id;
  logic [DISP_SIZE-1:0] grp_id;
  disp_t                inst;
  logic [LRQ_IDX_W-1:0] lrq_index;
  logic [STQ_SIZE-1:0]  stq_mask;
} ldq_entry_t;

typedef struct packed {
  logic                valid;
  disp_t               inst;
  logic [LDQ_SIZE-1:0] index_oh;
} replay_t;

typedef struct packed {
  logic                 update;
  logic [LDQ_SIZE-1:0]  index_oh;
  ex2_result_e          result;
  logic [LRQ_IDX_W-1:0] lrq_index;
  logic [STQ_SIZE-1:0]  stq_mask;  // Older stores blocking the load
} ex2_update_t;

typedef struct packed {
  logic                 valid;
  logic [LRQ_IDX_W-1:0] index;
} lrq_resolve_t;

typedef struct packed {
  logic                valid;
  logic [STQ_SIZE-1:0] index_oh;
} stq_resolve_t;

typedef struct packed {
  logic                 commit;
  logic [CMT_ID_W-1:0]  cmt_id;
  logic [DISP_SIZE-1:0] grp_id;
  logic                 flush_valid;
} commit_t;

typedef struct packed {
  logic                 valid;
  logic [CMT_ID_W-1:0]  cmt_id;
  logic [DISP_SIZE-1:0] grp_id;
} done_rpt_t;

typedef struct packed {
  logic             valid;
  logic [CNT_W-1:0] val;
} credit_ret_t;

endpackage

`default_nettype wire

// File: logic/ldq_ptr.sv
`default_nettype none

module ldq_ptr (
  input  logic                          i_clk,
  input  logic                          i_reset_n,

  input  logic                          i_rollback,

  input  logic                          i_in_valid,
  input  logic [ldq_pkg::LDQ_IDX_W-1:0] i_in_val,
  input  logic                          i_out_valid,
  input  logic [ldq_pkg::LDQ_IDX_W-1:0] i_out_val,

  output logic [ldq_pkg::LDQ_IDX_W-1:0] o_in_ptr,
  output logic [ldq_pkg::LDQ_IDX_W-1:0] o_out_ptr
);

logic [ldq_pkg::LDQ_IDX_W-1:0] r_in_ptr;
logic [ldq_pkg::LDQ_IDX_W-1:0] r_out_ptr;

// Queue size is a power of two, so the pointers wrap on their own
always_ff @(posedge i_clk) begin
  if (i_reset_n) begin
    r_in_ptr  <= '0;
    r_out_ptr <= '0;
  end else if (i_rollback) begin
    r_in_ptr <= r_out_ptr;  // Queue empties back to the oldest slot
  end else begin
    if (i_in_valid) begin
      r_in_ptr <= r_in_ptr + i_in_val;
    end
    if (i_out_valid) begin
      r_out_ptr <= r_out_ptr + i_out_val;
    end
  end
end

assign o_in_ptr  = r_in_ptr;
assign o_out_ptr = r_out_ptr;

endmodule

`default_nettype wire

// File: tests/ldq_sva.sv
`default_nettype none

module ldq_sva (
  input logic                         i_clk,
  input logic                         i_reset_n,
  input logic [ldq_pkg::CNT_W-1:0]    i_credits,
  input ldq_pkg::ldq_entry_t          i_entries [ldq_pkg::LDQ_SIZE],
  input logic [ldq_pkg::LDQ_SIZE-1:0] i_done_oh,
  input ldq_pkg::replay_t             i_replay,
  input ldq_pkg::credit_ret_t         i_credit_return
);

logic [ldq_pkg::CNT_W-1:0]    w_valid_cnt;
logic [ldq_pkg::LDQ_SIZE-1:0] w_ready_vec;
logic [ldq_pkg::LDQ_SIZE-1:0] w_done_vec;

always_comb begin
  w_valid_cnt = '0;
  w_ready_vec = '0;
  w_done_vec  = '0;
  for (int l = 0; l < ldq_pkg::LDQ_SIZE; l++) begin
    if (i_entries[l].is_valid) w_valid_cnt = w_valid_cnt + ldq_pkg::CNT_ONE;
    w_ready_vec[l] = i_entries[l].state == ldq_pkg::LDQ_READY;
    w_done_vec[l]  = i_entries[l].state == ldq_pkg::LDQ_EX3_DONE;
  end
end

// ----------------------------------------
credit_matches_entries: assert property (@(posedge i_clk) disable iff (i_reset_n)
  i_credits == w_valid_cnt) else $error("credit count differs from valid entries");

// Selects land on one entry of the matching state
replay_onehot: assert property (@(posedge i_clk) disable iff (i_reset_n)
  $onehot0(i_replay.index_oh) &&
  ((i_replay.index_oh & w_ready_vec) == i_replay.index_oh) &&
  ((|i_replay.index_oh) == (|w_ready_vec)))
  else $error("replay select not one-hot on a ready entry");

done_onehot: assert property (@(posedge i_clk) disable iff (i_reset_n)
  $onehot0(i_done_oh) &&
  ((i_done_oh & w_done_vec) == i_done_oh) &&
  ((|i_done_oh) == (|w_done_vec)))
  else $error("done select not one-hot on a done entry");

credit_nonzero: assert property (@(posedge i_clk) disable iff (i_reset_n)
  i_credit_return.valid |-> (i_credit_return.val != '0)) else $error("empty credit pulse");

endmodule

bind ldq ldq_sva u_ldq_sva (
  .i_clk           (i_clk),
  .i_reset_n       (i_reset_n),
  .i_credits       (u_credit_return.r_credits),
  .i_entries       (w_ldq_entries),
  .i_done_oh       (w_ldq_done_oh),
  .i_replay        (o_replay),
  .i_credit_return (o_credit_return)
);

`default_nettype wire

// File: tests/tb_ldq.sv
`default_nettype none

module tb_ldq;

localparam int NUM_ROWS = 8;
localparam int TIMEOUT  = 60 * NUM_ROWS + 5;

logic                          i_clk;
logic                          i_reset_n;
logic [ldq_pkg::DISP_SIZE-1:0] i_disp_valid;
ldq_pkg::disp_grp_t            i_disp;
ldq_pkg::ex2_update_t          i_ex2_update;
logic                          i_tlb_resolve;
ldq_pkg::lrq_resolve_t         i_lrq_resolve;
ldq_pkg::stq_resolve_t         i_stq_resolve;
ldq_pkg::commit_t              i_commit;
logic                          i_replay_conflict;
ldq_pkg::replay_t              o_replay;
ldq_pkg::done_rpt_t            o_done_report;
ldq_pkg::credit_ret_t          o_credit_return;

// Stimulus table
string                 row_name [NUM_ROWS];
int                    row_num  [NUM_ROWS];
int                    row_cmt  [NUM_ROWS];
ldq_pkg::ex2_result_e  row_res  [NUM_ROWS][2];
int                    row_conf [NUM_ROWS];  // Negative means random length
bit                    row_flush[NUM_ROWS];

int cycle_cnt;
int error_cnt;
int alloc_ptr;
int dispatched;
int returned = 0;

ldq UUT (.*);

initial i_clk = 1'b0;
always #2 i_clk = ~i_clk;

always @(posedge i_clk) begin
  cycle_cnt <= cycle_cnt + 1;
  if (cycle_cnt > TIMEOUT) begin
    $display("timeout: the DUT stopped responding before the tests ended");
    $display("Simulation FAILED");
    $fatal(1, "timeout");
  end
end

// Sums every credit pulse seen on the bus
always @(negedge i_clk) begin
  if (o_credit_return.valid === 1'b1) begin
    returned <= returned + int'(o_credit_return.val);
  end
end

task automatic step();
  @(posedge i_clk);
  #1;
endtask

task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
  if (exp !== act) begin
    error_cnt++;
    $display("error %s expected %0h actual %0h", name, exp, act);
    $display("Simulation FAILED");
    $fatal(1, "mismatch");
  end
endtask

task automatic add_row(input int r, input string name, input int num, input int cmt,
                       input ldq_pkg::ex2_result_e r0, input ldq_pkg::ex2_result_e r1,
                       input int conf, input bit flush);
  row_name[r]  = name;
  row_num[r]   = num;
  row_cmt[r]   = cmt;
  row_res[r][0] = r0;
  row_res[r][1] = r1;
  row_conf[r]  = conf;
  row_flush[r] = flush;
endtask

function automatic ldq_pkg::disp_t make_inst(input int r, input int k);
  ldq_pkg::disp_t d;
  d.pc_addr = 32'h1000 + r * 16 + k * 4;
  d.inst    = 32'h0000_2003 | (r << 20) | (k << 15);
  return d;
endfunction

task automatic dispatch(input int r, input int num);
  i_disp_valid = (num == 2) ? 2'b11 : 2'b01;
  i_disp.cmt_id = row_cmt[r][ldq_pkg::CMT_ID_W-1:0];
  for (int k = 0; k < 2; k++) i_disp.inst[k] = make_inst(r, k);
endtask

task automatic run_load(input int r, input int k, input int slot);
  ldq_pkg::ex2_result_e cur;
  logic [7:0]           exp_oh;
  int                   conf;
  bit                   finished;
  cur      = row_res[r][k];
  exp_oh   = 8'(1 << slot);
  finished = 0;
  for (int pass = 0; pass < 2 && !finished; pass++) begin
    while (!o_replay.valid) step();
    check({row_name[r], " offer index"}, exp_oh, o_replay.index_oh);
    check({row_name[r], " offer inst"}, make_inst(r, k), o_replay.inst);
    conf = (row_conf[r] < 0) ? int'($urandom % 4) : row_conf[r];
    for (int i = 0; i < conf; i++) begin
      step();
      check({row_name[r], " held index"}, exp_oh, o_replay.index_oh);
      check({row_name[r], " held inst"}, make_inst(r, k), o_replay.inst);
    end
    i_replay_conflict = 1'b0;  // Accept at the next edge
    step();
    i_replay_conflict = 1'b1;
    i_ex2_update.update    = 1'b1;
    i_ex2_update.index_oh  = exp_oh;
    i_ex2_update.result    = cur;
    i_ex2_update.lrq_index = 2'd2;
    i_ex2_update.stq_mask  = 8'b0000_0100;
    step();
    i_ex2_update = '0;
    if (cur == ldq_pkg::EX2_OK) begin
      check({row_name[r], " done valid"}, 1, o_done_report.valid);
      check({row_name[r], " done cmt_id"}, row_cmt[r], o_done_report.cmt_id);
      check({row_name[r], " done grp_id"}, 1 << k, o_done_report.grp_id);
      finished = 1;
    end else begin
      check({row_name[r], " parked"}, 0, o_replay.index_oh[slot]);
      if (cur != ldq_pkg::EX2_TLB_MISS) begin
        // Wrong resolve first
        i_lrq_resolve = '{valid: (cur == ldq_pkg::EX2_LRQ_MISS), index: 2'd1};
        i_stq_resolve = '{valid: (cur == ldq_pkg::EX2_STQ_HAZ), index_oh: 8'b0001_0000};
        step();
        check({row_name[r], " still parked"}, 0, o_replay.index_oh[slot]);
        i_lrq_resolve.index    = 2'd2;
        i_stq_resolve.index_oh = 8'b0000_0100;
      end else begin
        i_tlb_resolve = 1'b1;
      end
      step();
      i_lrq_resolve = '0;
      i_stq_resolve = '0;
      i_tlb_resolve = 1'b0;
      cur = ldq_pkg::EX2_OK;
    end
  end
endtask

initial begin
  int slot [2];
  int first;
  void'($urandom(41));
  cycle_cnt = 0;
  error_cnt = 0;
  alloc_ptr = 0;
  dispatched = 0;
  i_reset_n = 1'b1;
  i_disp_valid = '0;
  i_disp = '0;
  i_ex2_update = '0;
  i_tlb_resolve = 1'b0;
  i_lrq_resolve = '0;
  i_stq_resolve = '0;
  i_commit = '0;
  i_replay_conflict = 1'b1;

  add_row(0, "single_ok", 1, 1, ldq_pkg::EX2_OK, ldq_pkg::EX2_OK, 0, 0);
  add_row(1, "pair_ok", 2, 2, ldq_pkg::EX2_OK, ldq_pkg::EX2_OK, 1, 0);
  add_row(2, "lrq_hazard", 2, 3, ldq_pkg::EX2_LRQ_MISS, ldq_pkg::EX2_OK, 0, 0);
  add_row(3, "stq_hazard", 2, 4, ldq_pkg::EX2_OK, ldq_pkg::EX2_STQ_HAZ, 2, 0);
  add_row(4, "tlb_wrap", 2, 5, ldq_pkg::EX2_TLB_MISS, ldq_pkg::EX2_TLB_MISS, 0, 0);
  add_row(5, "rand_conflict", 1, 6, ldq_pkg::EX2_OK, ldq_pkg::EX2_OK, -1, 0);
  add_row(6, "flush", 2, 7, ldq_pkg::EX2_OK, ldq_pkg::EX2_OK, 0, 1);
  add_row(7, "after_flush", 2, 8, ldq_pkg::EX2_LRQ_MISS, ldq_pkg::EX2_STQ_HAZ, -1, 0);

  repeat (5) @(posedge i_clk);
  #1;
  i_reset_n = 1'b0;
  check("reset replay", 0, o_replay.valid);
  check("reset done", 0, o_done_report.valid);
  check("reset credit", 0, o_credit_return.valid);

  for (int r = 0; r < NUM_ROWS; r++) begin
    slot[0] = alloc_ptr;
    slot[1] = (alloc_ptr + 1) % ldq_pkg::LDQ_SIZE;
    dispatch(r, row_num[r]);
    step();
    i_disp_valid = '0;
    dispatched += row_num[r];
    if (row_flush[r]) begin
      dispatch(r, 1);  // Discarded by the flush
      i_commit = '{commit: 1'b1, cmt_id: '0, grp_id: '0, flush_valid: 1'b1};
      step();
      i_disp_valid = '0;
      i_commit = '0;
      dispatched += 1;
      check({row_name[r], " credit valid"}, 1, o_credit_return.valid);
      check({row_name[r], " credit val"}, row_num[r] + 1, o_credit_return.val);
      check({row_name[r], " queue empty"}, 0, o_replay.valid);
    end else begin
      // Lowest slot is offered first
      first = (row_num[r] == 2 && slot[1] < slot[0]) ? 1 : 0;
      run_load(r, first, slot[first]);
      if (row_num[r] == 2) run_load(r, 1 - first, slot[1 - first]);
      i_commit = '{commit: 1'b1, cmt_id: row_cmt[r][ldq_pkg::CMT_ID_W-1:0],
                   grp_id: 2'b11, flush_valid: 1'b0};
      step();
      i_commit = '0;
      check({row_name[r], " credit valid"}, 1, o_credit_return.valid);
      check({row_name[r], " credit val"}, row_num[r], o_credit_return.val);
      alloc_ptr = (alloc_ptr + row_num[r]) % ldq_pkg::LDQ_SIZE;
    end
    step();
  end

  check("credit total", dispatched, returned);
  if (error_cnt == 0) begin
    $display("Simulation PASSED");
  end else begin
    $display("Simulation FAILED");
  end
  $finish;
end

endmodule

`default_nettype wire

// File: verilog.f
logic/ldq_pkg.sv
logic/ldq_entry.sv
logic/ldq_ptr.sv
logic/ldq_credit_return.sv
logic/ldq.sv
tests/ldq_sva.sv
tests/tb_ldq.sv
